//--- nn_core_top.f
+incdir+.
nn_types_pkg.sv
nn_dma_pkg.sv
weight_dma.sv
weight_buffer.sv
fc_classifier.sv
nn_core_top.sv
tb_nn_core_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --assert \
  -f nn_core_top.f \
  --top-module tb_nn_core_top \
  -o sim_nn_core \
  && ./obj_dir/sim_nn_core \
  || { echo "simulation did not complete successfully"; exit 1; }

//--- tb_nn_core_top.sv
`timescale 1ns/1ps
`include "nn_core_macros.svh"

module tb_nn_core_top
  import nn_types_pkg::*;
  import nn_dma_pkg::*;
();

  typedef weight_t weight_arr_t [`NN_WEIGHT_COUNT];

  logic         clk;
  logic         rst_n;
  logic         i_start;
  feature_vec_t i_parallel_data;
  logic         i_fm_data_valid;
  sram_addr_t   o_sram_weight_addr;
  weight_t      i_sram_weight;
  logic         o_data_ready;
  logic         o_dma_finish;
  class_t       o_result_data;
  acc_t         o_result_score;
  logic         o_result_data_valid;

  weight_arr_t  sram;                         // external weight sram contents
  bit           seen [`NN_WEIGHT_COUNT];      // addresses requested by the dma
  result_t      exp_q [$];
  result_t      exp_res;
  int           ready_count;
  int           result_count;
  integer       seed;
  string        test_name;
  feature_vec_t vec;

  nn_core_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // synchronous read, data one cycle after the address
  always @(posedge clk) begin
    i_sram_weight <= sram[o_sram_weight_addr[`NN_BUF_ADDR_W-1:0]];
    if (o_sram_weight_addr < sram_addr_t'(`NN_WEIGHT_COUNT)) begin
      seen[o_sram_weight_addr[`NN_BUF_ADDR_W-1:0]] = 1'b1;
    end
  end

  always @(negedge clk) begin
    if (rst_n && o_data_ready) begin
      ready_count++;
    end
  end

  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected !== actual) begin
      $display("Mismatch %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
    end
  endtask

  // argmax over class-major weights, ties keep the lower class
  function automatic result_t ref_classify(input weight_arr_t w, input feature_vec_t v);
    result_t r;
    int      score;
    int      best_score;
    int      best_cls;
    best_score = 0;
    best_cls   = 0;
    for (int c = 0; c < `NN_NUM_CLASSES; c++) begin
      score = 0;
      for (int k = 0; k < `NN_VEC_LEN; k++) begin
        score += int'(v[k]) * int'(w[c * `NN_VEC_LEN + k]);
      end
      if (c == 0 || score > best_score) begin
        best_score = score;
        best_cls   = c;
      end
    end
    r.cls   = class_t'(best_cls);
    r.score = acc_t'(best_score);
    return r;
  endfunction

  always @(negedge clk) begin
    if (rst_n && o_result_data_valid) begin
      if (exp_q.size() == 0) begin
        fail_stop($sformatf("%s: result strobe with no vector outstanding", test_name));
      end else begin
        exp_res = exp_q.pop_front();
        check_value("class", int'(exp_res.cls), int'(o_result_data));
        check_value("score", int'(exp_res.score), int'(o_result_score));
        result_count++;
      end
    end
  end

  function automatic feature_vec_t random_vector();
    feature_vec_t v;
    for (int k = 0; k < `NN_VEC_LEN; k++) begin
      v[k] = feature_t'($random(seed));
    end
    return v;
  endfunction

  task automatic send_vector(input feature_vec_t v, input bit expect_result);
    if (expect_result) begin
      exp_q.push_back(ref_classify(sram, v));
    end
    @(posedge clk);
    i_parallel_data <= v;
    i_fm_data_valid <= 1'b1;
    @(posedge clk);
    i_fm_data_valid <= 1'b0;
  endtask

  task automatic wait_results(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (result_count < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        fail_stop($sformatf("%s: timed out waiting for a classification result", test_name));
      end
    end
  endtask

  task automatic load_weights(input bit extra_start);
    int base;
    int cycles;
    @(negedge clk);
    base = ready_count;
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    @(negedge clk);
    foreach (seen[a]) seen[a] = 1'b0;  // reads before the start do not count
    cycles = 1;                         // first cycle after the start was sampled
    while (!o_dma_finish) begin
      @(posedge clk);
      i_start <= (extra_start && cycles == 3);  // lands in READ, must be ignored
      @(negedge clk);
      cycles++;
      if (cycles > 100) begin
        fail_stop($sformatf("%s: timed out waiting for the weight load to finish", test_name));
      end
    end
    check_value("finish latency", `NN_WEIGHT_COUNT + 2, cycles);
    repeat (20) begin
      @(negedge clk);
      check_value("dma finish held", 1, int'(o_dma_finish));
    end
    check_value("ready pulses", base + 1, ready_count);
    for (int a = 0; a < `NN_WEIGHT_COUNT; a++) begin
      if (!seen[a]) begin
        fail_stop($sformatf("%s: sram address %0d never read by the dma", test_name, a));
      end
    end
  endtask

  initial begin
    result_t tie_res;
    seed            = 32'h9606;
    rst_n           = 1'b0;
    i_start         = 1'b0;
    i_parallel_data = '0;
    i_fm_data_valid = 1'b0;
    i_sram_weight   = '0;
    ready_count     = 0;
    result_count    = 0;
    for (int a = 0; a < `NN_WEIGHT_COUNT; a++) begin
      sram[a] = weight_t'($random(seed));
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "reset";
    @(negedge clk);
    check_value("data ready", 0, int'(o_data_ready));
    check_value("dma finish", 0, int'(o_dma_finish));
    check_value("result valid", 0, int'(o_result_data_valid));

    test_name = "strobe before load";
    send_vector(random_vector(), 1'b0);
    repeat (60) @(posedge clk);
    check_value("results", 0, result_count);

    test_name = "initial load";
    load_weights(1'b0);

    test_name = "random vectors";
    for (int n = 0; n < 20; n++) begin
      send_vector(random_vector(), 1'b1);
      wait_results(result_count + 1, 60);
    end

    test_name = "strobe while busy";
    send_vector(random_vector(), 1'b1);
    repeat (4) @(posedge clk);
    send_vector(random_vector(), 1'b0);  // dropped, classifier busy
    wait_results(result_count + 1, 60);
    repeat (60) @(posedge clk);
    check_value("results", 21, result_count);

    test_name = "reload";
    for (int c = 0; c < `NN_NUM_CLASSES; c++) begin
      for (int k = 0; k < `NN_VEC_LEN; k++) begin
        sram[c * `NN_VEC_LEN + k] = weight_t'((c == 1 || c == 3) ? 5 : c + 1);
      end
    end
    load_weights(1'b1);

    test_name = "argmax tie";
    for (int k = 0; k < `NN_VEC_LEN; k++) begin
      vec[k] = feature_t'(1);
    end
    tie_res.cls   = class_t'(1);             // rows 1 and 3 tie, lower class wins
    tie_res.score = acc_t'(5 * `NN_VEC_LEN);
    exp_q.push_back(tie_res);
    send_vector(vec, 1'b0);
    wait_results(result_count + 1, 60);

    test_name = "after reload";
    for (int n = 0; n < 3; n++) begin
      send_vector(random_vector(), 1'b1);
      wait_results(result_count + 1, 60);
    end

    repeat (5) @(posedge clk);
    if (exp_q.size() != 0) begin
      fail_stop("expected results still outstanding at the end of the run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- nn_core_top.sv
`timescale 1ns/1ps
`include "nn_core_macros.svh"

module nn_core_top
  import nn_types_pkg::*;
  import nn_dma_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         i_start,
  input  feature_vec_t i_parallel_data,
  input  logic         i_fm_data_valid,
  output sram_addr_t   o_sram_weight_addr,
  input  weight_t      i_sram_weight,
  output logic         o_data_ready,
  output logic         o_dma_finish,
  output class_t       o_result_data,
  output acc_t         o_result_score,
  output logic         o_result_data_valid
);

  buf_wr_t   buf_wr;     // dma to buffer
  buf_addr_t rd_addr;    // classifier read address
  weight_t   rd_weight;
  result_t   result;
  logic      finish_q;   // finish one cycle ago

  weight_dma u_weight_dma (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .o_sram_addr (o_sram_weight_addr),
    .i_sram_data (i_sram_weight),
    .o_buf_wr    (buf_wr),
    .o_finish    (o_dma_finish)
  );

  weight_buffer u_weight_buffer (
    .clk       (clk),
    .i_wr      (buf_wr),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_weight)
  );

  fc_classifier u_fc_classifier (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_weights_ready (o_dma_finish),
    .i_feat_valid    (i_fm_data_valid),
    .i_feat          (i_parallel_data),
    .o_rd_addr       (rd_addr),
    .i_weight        (rd_weight),
    .o_result        (result),
    .o_result_valid  (o_result_data_valid)
  );

  // ready pulse on the rising edge of finish
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      finish_q     <= 1'b0;
      o_data_ready <= 1'b0;
    end else begin
      finish_q     <= o_dma_finish;
      o_data_ready <= o_dma_finish && !finish_q;
    end
  end

  assign o_result_data  = result.cls;
  assign o_result_score = result.score;

endmodule

//--- fc_classifier.sv
`timescale 1ns/1ps
`include "nn_core_macros.svh"

module fc_classifier
  import nn_types_pkg::*;
  import nn_dma_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         i_weights_ready,
  input  logic         i_feat_valid,
  input  feature_vec_t i_feat,
  output buf_addr_t    o_rd_addr,
  input  weight_t      i_weight,
  output result_t      o_result,
  output logic         o_result_valid
);

  localparam int ELEM_W = $clog2(`NN_VEC_LEN);
  localparam class_t LAST_CLS = class_t'(`NN_NUM_CLASSES - 1);
  localparam logic [ELEM_W-1:0] LAST_ELEM = ELEM_W'(`NN_VEC_LEN - 1);

  // read stage
  logic              rd_busy;
  class_t            rd_cls;
  logic [ELEM_W-1:0] rd_elem;

  // mac stage, one cycle behind the read address
  logic              mac_vld;
  class_t            mac_cls;
  logic [ELEM_W-1:0] mac_elem;

  feature_vec_t feat_q;
  acc_t         acc;
  acc_t         sum;
  acc_t         best_score;
  class_t       best_cls;

  logic signed [`NN_FEAT_W+`NN_WEIGHT_W-1:0] prod;
  logic accept;
  logic class_end;
  logic take_new;

  // strobes while busy or before the weights are loaded are dropped
  assign accept    = i_feat_valid && i_weights_ready && !rd_busy && !mac_vld;
  assign prod      = feat_q[mac_elem] * i_weight;
  assign sum       = acc + acc_t'(prod);
  assign class_end = mac_vld && (mac_elem == LAST_ELEM);
  assign take_new  = (mac_cls == '0) || (sum > best_score);  // strict, ties keep lower class

  // class-major layout in the buffer
  assign o_rd_addr = buf_addr_t'(int'(rd_cls) * `NN_VEC_LEN + int'(rd_elem));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_busy        <= 1'b0;
      rd_cls         <= '0;
      rd_elem        <= '0;
      mac_vld        <= 1'b0;
      mac_cls        <= '0;
      mac_elem       <= '0;
      o_result_valid <= 1'b0;
    end else begin
      if (accept) begin
        rd_busy <= 1'b1;
        rd_cls  <= '0;
        rd_elem <= '0;
      end else if (rd_busy) begin
        if (rd_elem == LAST_ELEM) begin
          rd_elem <= '0;
          rd_cls  <= class_t'(rd_cls + 1'b1);
          if (rd_cls == LAST_CLS) begin
            rd_busy <= 1'b0;  // last address issued
          end
        end else begin
          rd_elem <= rd_elem + 1'b1;
        end
      end
      mac_vld        <= rd_busy;
      mac_cls        <= rd_cls;
      mac_elem       <= rd_elem;
      o_result_valid <= class_end && (mac_cls == LAST_CLS);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      feat_q <= i_feat;
      acc    <= '0;
    end else if (mac_vld) begin
      acc <= class_end ? '0 : sum;  // restart for the next class
    end
    if (class_end && take_new) begin
      best_score <= sum;
      best_cls   <= mac_cls;
    end
    if (class_end && (mac_cls == LAST_CLS)) begin
      o_result.cls   <= take_new ? mac_cls : best_cls;
      o_result.score <= take_new ? sum : best_score;
    end
  end

  // one result per accepted vector, never back to back
  a_result_single : assert property (
    @(posedge clk) disable iff (!rst_n)
    o_result_valid |=> !o_result_valid
  );

endmodule

//--- weight_buffer.sv
`timescale 1ns/1ps
`include "nn_core_macros.svh"

module weight_buffer
  import nn_types_pkg::*;
  import nn_dma_pkg::*;
(
  input  logic      clk,
  input  buf_wr_t   i_wr,
  input  buf_addr_t i_rd_addr,
  output weight_t   o_rd_data
);

  weight_t mem [`NN_WEIGHT_COUNT];

  always_ff @(posedge clk) begin
    if (i_wr.en) begin
      mem[i_wr.addr] <= i_wr.data;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

  // the dma must never hand over a write without a clean address
  a_wr_addr_known : assert property (
    @(posedge clk) i_wr.en |-> !$isunknown(i_wr.addr)
  );

endmodule

//--- weight_dma.sv
`timescale 1ns/1ps
`include "nn_core_macros.svh"

module weight_dma
  import nn_types_pkg::*;
  import nn_dma_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_start,
  output sram_addr_t o_sram_addr,
  input  weight_t    i_sram_data,
  output buf_wr_t    o_buf_wr,
  output logic       o_finish
);

  localparam sram_addr_t LAST_ADDR = sram_addr_t'(`NN_WEIGHT_COUNT - 1);

  dma_state_t state;
  sram_addr_t addr_cnt;  // address on the sram port
  logic       wr_en_q;   // word returns this cycle
  buf_addr_t  wr_addr_q; // address that word belongs to

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      addr_cnt <= '0;
    end else begin
      case (state)
        IDLE, DONE: begin
          if (i_start) begin  // restart from DONE reloads
            state    <= READ;
            addr_cnt <= '0;
          end
        end
        READ: begin
          if (addr_cnt == LAST_ADDR) begin
            state <= DRAIN;
          end else begin
            addr_cnt <= addr_cnt + 1'b1;
          end
        end
        DRAIN: state <= DONE;  // last write goes out this cycle
        default: state <= IDLE;
      endcase
    end
  end

  // pair each returned word with the address that fetched it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_en_q   <= 1'b0;
      wr_addr_q <= '0;
    end else begin
      wr_en_q   <= (state == READ);
      wr_addr_q <= buf_addr_t'(addr_cnt);
    end
  end

  assign o_sram_addr = addr_cnt;
  assign o_buf_wr    = '{en: wr_en_q, addr: wr_addr_q, data: i_sram_data};
  assign o_finish    = (state == DONE);

  // each write comes from an address inside the layer
  a_wr_addr_in_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    o_buf_wr.en |-> ($past(o_sram_addr) < sram_addr_t'(`NN_WEIGHT_COUNT))
  );

endmodule

//--- nn_dma_pkg.sv
`include "nn_core_macros.svh"

package nn_dma_pkg;

  typedef logic [`NN_ADDR_W-1:0] sram_addr_t;

  typedef logic [`NN_BUF_ADDR_W-1:0] buf_addr_t;

  // write request towards the weight buffer
  typedef struct packed {
    logic                 en;
    buf_addr_t            addr;
    nn_types_pkg::weight_t data;
  } buf_wr_t;

  typedef enum logic [1:0] {
    IDLE,  // nothing loaded yet
    READ,  // issuing sram addresses
    DRAIN, // last word still in flight
    DONE   // buffer holds a full layer
  } dma_state_t;

endpackage

//--- nn_types_pkg.sv
`include "nn_core_macros.svh"

package nn_types_pkg;

  // signed feature as delivered on the parallel input
  typedef logic signed [`NN_FEAT_W-1:0] feature_t;

  // one class weight, one per sram word
  typedef logic signed [`NN_WEIGHT_W-1:0] weight_t;

  // accumulator, also the reported score
  typedef logic signed [`NN_ACC_W-1:0] acc_t;

  typedef logic [`NN_CLASS_W-1:0] class_t;

  // element k at bits 8k+7..8k
  typedef feature_t [`NN_VEC_LEN-1:0] feature_vec_t;

  typedef struct packed {
    class_t cls;   // winning class
    acc_t   score; // its score
  } result_t;

endpackage

//--- nn_core_macros.svh
`ifndef NN_CORE_MACROS_SVH
`define NN_CORE_MACROS_SVH

// classifier geometry
`define NN_NUM_CLASSES   4
`define NN_VEC_LEN       8
`define NN_WEIGHT_COUNT  (`NN_NUM_CLASSES * `NN_VEC_LEN)   // one weight per sram word

// data path widths
`define NN_FEAT_W        8
`define NN_WEIGHT_W      16
`define NN_ACC_W         32
`define NN_CLASS_W       2

// address widths
`define NN_ADDR_W        16   // external weight sram
`define NN_BUF_ADDR_W    5    // on-chip weight buffer

`endif
